/* hdl/uart_alu_pkg.sv */
package uart_alu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Serial line timing.
  //////////////////////////////////////////////////////////////////////

  localparam int CLK_FREQ_HZ = 100_000_000;  // System clock.
  localparam int BAUD_RATE   = 115_200;      // Line rate.
  localparam int OVERSAMPLE  = 16;           // Ticks per bit.

  // Clocks per oversample tick, truncated.
  localparam int BAUD_DIV    = CLK_FREQ_HZ / (BAUD_RATE * OVERSAMPLE);

  localparam int STOP_BITS   = 2;            // Stop bits on transmit.
  localparam int DATA_W      = 8;            // Bits per frame payload.

  //////////////////////////////////////////////////////////////////////
  // Data types.
  //////////////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;         // Serial byte, operand or result.
  typedef logic [7:0]        opcode_t;       // ALU function select.

  // One complete command for the ALU.
  typedef struct packed {
    opcode_t opcode;                         // Third byte received.
    data_t   a;                              // First byte received.
    data_t   b;                              // Second byte received.
  } alu_req_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes.
  //////////////////////////////////////////////////////////////////////

  // Arithmetic.
  localparam opcode_t OP_ADD = 8'h20;
  localparam opcode_t OP_SUB = 8'h22;
  // Bitwise logic.
  localparam opcode_t OP_AND = 8'h24;
  localparam opcode_t OP_OR  = 8'h25;
  localparam opcode_t OP_XOR = 8'h26;
  localparam opcode_t OP_NOR = 8'h27;
  // Right shifts of a by b.
  localparam opcode_t OP_SRL = 8'h02;
  localparam opcode_t OP_SRA = 8'h03;

endpackage

/* hdl/baud_rate_generator.sv */
`timescale 1ns/1ns

module baud_rate_generator
  import uart_alu_pkg::*;
(
  input  logic i_clock,   // System clock.
  input  logic i_arst_n,  // Async reset, active low.
  output logic o_tick     // One clock every BAUD_DIV clocks.
);

  // Free running divider.
  logic [$clog2(BAUD_DIV)-1:0] div_cnt;
  logic                        wrap;

  assign wrap = (div_cnt == BAUD_DIV - 1);  // Last clock of the period.

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      div_cnt <= '0;
      o_tick  <= 1'b0;
    end else begin
      o_tick <= wrap;                       // Registered, single cycle.
      if (wrap) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx
  import uart_alu_pkg::*;
(
  input  logic  i_clock,   // System clock.
  input  logic  i_arst_n,  // Async reset, active low.
  input  logic  i_tick,    // 16x oversample tick.
  input  logic  i_rxd,     // Serial in, idles high.
  output logic  o_valid,   // One cycle per good frame.
  output data_t o_data     // Received byte.
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t                     state;
  logic [1:0]                    rxd_sync;   // Metastability chain.
  logic                          rxd_s;
  logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;   // Ticks within a bit.
  logic [$clog2(DATA_W)-1:0]     bit_cnt;    // Data bit index.
  data_t                         shreg;      // LSB first shifter.
  logic                          bit_mid;

  assign rxd_s   = rxd_sync[1];
  assign bit_mid = i_tick && (tick_cnt == OVERSAMPLE - 1);  // One bit after last sample.
  assign o_data  = shreg;

  //////////////////////////////////////////////////////////////////////
  // Input synchroniser.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rxd_sync <= 2'b11;                       // Line idle.
    end else begin
      rxd_sync <= {rxd_sync[0], i_rxd};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame FSM.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      o_valid  <= 1'b0;
    end else begin
      o_valid <= 1'b0;                         // Pulse only.
      case (state)
        ST_IDLE: begin
          if (!rxd_s) begin                    // Falling start edge.
            state    <= ST_START;
            tick_cnt <= '0;
          end
        end
        ST_START: begin
          if (i_tick) begin
            if (tick_cnt == OVERSAMPLE / 2 - 1) begin
              // Middle of start bit, low again means a real frame.
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= rxd_s ? ST_IDLE : ST_DATA;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        ST_DATA: begin
          if (i_tick) begin
            tick_cnt <= tick_cnt + 1'b1;       // Wraps at OVERSAMPLE.
            if (bit_mid) begin
              if (bit_cnt == DATA_W - 1) begin
                state <= ST_STOP;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
        end
        ST_STOP: begin
          if (i_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (bit_mid) begin
              o_valid <= rxd_s;                // Low stop bit drops the byte.
              state   <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data shifter.
  always_ff @(posedge i_clock) begin
    if (state == ST_DATA && bit_mid) begin
      shreg <= {rxd_s, shreg[DATA_W-1:1]};     // LSB arrives first.
    end
  end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
  import uart_alu_pkg::*;
(
  input  logic  i_clock,   // System clock.
  input  logic  i_arst_n,  // Async reset, active low.
  input  logic  i_tick,    // 16x oversample tick.
  input  logic  i_valid,   // Byte offered.
  output logic  o_ready,   // High only when idle.
  input  data_t i_data,    // Byte to send.
  output logic  o_txd      // Serial out, idles high.
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ALIGN,                                  // Wait for the first tick.
    ST_SEND
  } tx_state_t;

  tx_state_t                             state;
  logic [DATA_W+STOP_BITS:0]             shreg;     // Start, data, stop bits.
  logic [$clog2(OVERSAMPLE)-1:0]         tick_cnt;
  logic [$clog2(DATA_W+STOP_BITS+1)-1:0] bit_cnt;   // Bit index in frame.
  logic                                  fire, bit_end, last_bit, shift_en;

  assign o_ready  = (state == ST_IDLE);
  assign fire     = i_valid && o_ready;                      // Handshake.
  assign bit_end  = i_tick && (tick_cnt == OVERSAMPLE - 1);
  assign last_bit = (bit_cnt == DATA_W + STOP_BITS);         // Final stop bit.
  assign shift_en = (state == ST_ALIGN && i_tick) ||
                    (state == ST_SEND && bit_end && !last_bit);

  // Control path.
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      o_txd    <= 1'b1;                        // Mark.
    end else begin
      if (shift_en) begin
        o_txd <= shreg[0];                     // Next bit onto the line.
      end
      case (state)
        ST_IDLE: begin
          if (fire) state <= ST_ALIGN;
        end
        ST_ALIGN: begin
          if (i_tick) begin                    // Start bit begins here.
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (i_tick) tick_cnt <= tick_cnt + 1'b1;
          if (bit_end) begin
            if (last_bit) begin
              o_txd <= 1'b1;
              state <= ST_IDLE;                // Ready again.
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Frame shifter.
  always_ff @(posedge i_clock) begin
    if (fire) begin
      shreg <= {{STOP_BITS{1'b1}}, i_data, 1'b0};
    end else if (shift_en) begin
      shreg <= {1'b1, shreg[DATA_W+STOP_BITS:1]};  // Mark fills from the top.
    end
  end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu
  import uart_alu_pkg::*;
(
  input  alu_req_t i_req,     // Opcode and two operands.
  output data_t    o_result   // Combinational result.
);

  // Shift distance from b.
  logic [$clog2(DATA_W)-1:0] shamt;

  assign shamt = i_req.b[$clog2(DATA_W)-1:0];  // Low bits only.

  //////////////////////////////////////////////////////////////////////
  // Opcode decode.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_req.opcode)
      OP_ADD: begin
        o_result = i_req.a + i_req.b;          // Carry dropped.
      end
      OP_SUB: begin
        o_result = i_req.a - i_req.b;          // Borrow dropped.
      end
      OP_AND: o_result = i_req.a & i_req.b;
      OP_OR:  o_result = i_req.a | i_req.b;
      OP_XOR: o_result = i_req.a ^ i_req.b;
      OP_NOR: o_result = ~(i_req.a | i_req.b);
      OP_SRL: begin
        o_result = i_req.a >> shamt;           // Zero fill.
      end
      OP_SRA: begin
        // Sign bit of a fills from the left.
        o_result = data_t'($signed(i_req.a) >>> shamt);
      end
      default: begin
        o_result = '0;                         // Unknown opcode.
      end
    endcase
  end

endmodule

/* hdl/interface_circuit.sv */
`timescale 1ns/1ns

module interface_circuit
  import uart_alu_pkg::*;
(
  input  logic       i_clock,     // System clock.
  input  logic       i_arst_n,    // Async reset, active low.
  input  logic       i_rx_valid,  // One cycle per received byte.
  input  data_t      i_rx_data,   // Received byte.
  input  data_t      i_result,    // ALU output.
  output alu_req_t   o_req,       // Command to the ALU.
  output logic       o_tx_valid,  // Result waiting for the transmitter.
  input  logic       i_tx_ready,  // Transmitter idle.
  output data_t      o_tx_data,   // Result byte.
  output logic [3:0] o_leds       // Low nibble of last byte.
);

  logic [1:0] byte_cnt;           // 0 a, 1 b, 2 opcode.
  alu_req_t   req_q;              // Command registers.
  logic       calc_pend;          // Opcode written, result not yet taken.
  logic       tx_fire;
  logic       load_res;

  assign o_req    = req_q;
  assign tx_fire  = o_tx_valid && i_tx_ready;
  // Take the result once the output register is free.
  assign load_res = calc_pend && (!o_tx_valid || tx_fire);

  //////////////////////////////////////////////////////////////////////
  // Byte collection.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      byte_cnt <= '0;
      o_leds   <= '0;
    end else if (i_rx_valid) begin
      o_leds <= i_rx_data[3:0];               // Every byte shows.
      if (byte_cnt == 2'd2) begin
        byte_cnt <= '0;                        // Command complete.
      end else begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // Operand and opcode registers.
  always_ff @(posedge i_clock) begin
    if (i_rx_valid) begin
      case (byte_cnt)
        2'd0:    req_q.a      <= i_rx_data;
        2'd1:    req_q.b      <= i_rx_data;
        default: req_q.opcode <= i_rx_data;  // Starts the ALU.
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result register and handshake.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      calc_pend  <= 1'b0;
      o_tx_valid <= 1'b0;
    end else begin
      if (tx_fire) begin
        o_tx_valid <= 1'b0;                    // Transmitter took it.
      end
      if (load_res) begin
        o_tx_valid <= 1'b1;                    // ALU settled a cycle ago.
        calc_pend  <= 1'b0;
      end
      if (i_rx_valid && byte_cnt == 2'd2) begin
        calc_pend <= 1'b1;
      end
    end
  end

  // Held stable until the handshake.
  always_ff @(posedge i_clock) begin
    if (load_res) begin
      o_tx_data <= i_result;
    end
  end

endmodule

/* hdl/uart_alu_top.sv */
`timescale 1ns/1ns

module uart_alu_top
  import uart_alu_pkg::*;
(
  input  logic       i_clock,   // 100 MHz system clock.
  input  logic       i_arst_n,  // Async reset, active low.
  input  logic       i_rxd,     // Serial from host.
  output logic       o_txd,     // Serial to host.
  output logic [3:0] o_leds     // Status nibble.
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect.
  //////////////////////////////////////////////////////////////////////

  logic     tick;               // Shared 16x tick.
  logic     rx_valid;
  data_t    rx_data;
  alu_req_t req;                // Collector to ALU.
  data_t    result;             // ALU to collector.
  logic     tx_valid, tx_ready;
  data_t    tx_data;

  baud_rate_generator u_baud_rate_generator (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .o_tick   (tick)
  );

  // Host to design.
  uart_rx u_uart_rx (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .i_tick   (tick),
    .i_rxd    (i_rxd),
    .o_valid  (rx_valid),
    .o_data   (rx_data)
  );

  interface_circuit u_interface_circuit (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_rx_valid (rx_valid),
    .i_rx_data  (rx_data),
    .i_result   (result),
    .o_req      (req),
    .o_tx_valid (tx_valid),
    .i_tx_ready (tx_ready),
    .o_tx_data  (tx_data),
    .o_leds     (o_leds)
  );

  alu u_alu (
    .i_req    (req),
    .o_result (result)
  );

  // Design to host.
  uart_tx u_uart_tx (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .i_tick   (tick),
    .i_valid  (tx_valid),
    .o_ready  (tx_ready),
    .i_data   (tx_data),
    .o_txd    (o_txd)
  );

endmodule

/* test/tb_uart_alu_top.sv */
`timescale 1ns/1ns

module tb_uart_alu_top
  import uart_alu_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // Timing and run length.
  //////////////////////////////////////////////////////////////////////

  localparam int CLK_NS      = 4;
  localparam int BIT_CLKS    = OVERSAMPLE * BAUD_DIV;    // 864 clocks per bit.
  localparam int FRAME_BITS  = 1 + DATA_W + STOP_BITS;   // Start, data, stops.
  // Frames per test, one command counted as four.
  localparam int N_FRAMES    = 1 + 10 * 4 + 20 * 4 + 4 * 4 + 12 + 6;
  localparam int WATCHDOG_NS = N_FRAMES * FRAME_BITS * BIT_CLKS * CLK_NS / 10 * 12;

  logic        i_clock = 1'b0;
  logic        i_arst_n, i_rxd;
  logic        o_txd;
  logic [3:0]  o_leds;
  logic [31:0] rng_state = 32'h7389;                     // Xorshift state.
  opcode_t     valid_ops [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
                                 OP_XOR, OP_NOR, OP_SRL, OP_SRA};

  uart_alu_top uut (.i_clock, .i_arst_n, .i_rxd, .o_txd, .o_leds);

  initial begin
    forever #(CLK_NS / 2) i_clock = ~i_clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Model, random source and checks.
  //////////////////////////////////////////////////////////////////////

  function automatic data_t expected_result(input opcode_t op, input data_t a,
                                            input data_t b);
    int    sh, k;
    data_t r;
    sh = b % 8;                                          // Low three bits of b.
    case (op)
      OP_ADD:  r = data_t'((int'(a) + int'(b)) % 256);
      OP_SUB:  r = data_t'((int'(a) - int'(b) + 256) % 256);
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_NOR:  r = ~(a | b);
      OP_SRL:  r = data_t'(int'(a) / (1 << sh));
      OP_SRA: begin
        r = a;
        for (k = 0; k < sh; k++) r = {a[7], r[7:1]};    // Copy sign in.
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) abort_run($sformatf("ERROR %s expected 0x%02h actual 0x%02h",
                                         name, exp, act));
  endtask

  task automatic check_leds(input string name, input logic [3:0] exp,
                            input logic [3:0] act);
    if (act !== exp) abort_run($sformatf("ERROR %s expected 0x%01h actual 0x%01h",
                                         name, exp, act));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Serial driver and monitor, both aligned to falling edges.
  //////////////////////////////////////////////////////////////////////

  task automatic drive_bit(input logic level, input int clocks);
    i_rxd = level;
    repeat (clocks) @(negedge i_clock);
  endtask

  task automatic send_byte(input data_t value, input logic bad_stop);
    int i;
    drive_bit(1'b0, BIT_CLKS);                           // Start bit.
    for (i = 0; i < DATA_W; i++) drive_bit(value[i], BIT_CLKS);
    if (bad_stop) begin
      // Low over the sample point, released before a false start is confirmed.
      drive_bit(1'b0, BIT_CLKS * 3 / 4);
      drive_bit(1'b1, BIT_CLKS / 4);
    end else begin
      drive_bit(1'b1, BIT_CLKS);
    end
    drive_bit(1'b1, BIT_CLKS);                           // Second stop bit.
  endtask

  task automatic recv_byte(output data_t value);
    int i;
    while (o_txd !== 1'b0) @(negedge i_clock);           // Start edge.
    repeat (BIT_CLKS / 2) @(negedge i_clock);
    if (o_txd !== 1'b0) abort_run("Start bit on o_txd did not stay low to mid-bit.");
    for (i = 0; i < DATA_W; i++) begin
      repeat (BIT_CLKS) @(negedge i_clock);
      value[i] = o_txd;                                  // LSB first.
    end
    for (i = 0; i < STOP_BITS; i++) begin
      repeat (BIT_CLKS) @(negedge i_clock);
      if (o_txd !== 1'b1) abort_run("Stop bit on o_txd was low where it must be high.");
    end
  endtask

  // One command out, one result back.
  task automatic run_command(input string name, input data_t a, input data_t b,
                             input opcode_t op);
    data_t got;
    fork
      begin
        send_byte(a, 1'b0);
        send_byte(b, 1'b0);
        send_byte(op, 1'b0);
      end
      recv_byte(got);
    join
    check_data(name, expected_result(op, a, b), got);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests.
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_idle();
    repeat (FRAME_BITS * BIT_CLKS) begin
      @(negedge i_clock);
      if (o_txd !== 1'b1) abort_run("o_txd left idle after reset with no command sent.");
    end
    check_leds("reset_idle", 4'h0, o_leds);
  endtask

  task automatic test_each_opcode();
    int      i;
    data_t   a_set [10] = '{8'h35, 8'hF0, 8'h10, 8'hC3, 8'hA0,
                            8'h5A, 8'h0F, 8'hB6, 8'h96, 8'h64};
    data_t   b_set [10] = '{8'h4A, 8'h25, 8'h20, 8'h5E, 8'h05,
                            8'hFF, 8'h30, 8'h03, 8'h02, 8'h05};
    opcode_t op_set [10] = '{OP_ADD, OP_ADD, OP_SUB, OP_AND, OP_OR,
                             OP_XOR, OP_NOR, OP_SRL, OP_SRA, OP_SRA};
    for (i = 0; i < 10; i++) begin                       // Overflow add, negative SRA.
      run_command($sformatf("each_opcode_%02h", op_set[i]), a_set[i], b_set[i], op_set[i]);
    end
  endtask

  task automatic test_random_commands();
    int      i;
    data_t   a, b;
    opcode_t op;
    for (i = 0; i < 20; i++) begin
      rng_state = xorshift32(rng_state);
      a  = rng_state[7:0];
      b  = rng_state[15:8];
      op = valid_ops[rng_state[18:16]];
      run_command("random_commands", a, b, op);
    end
    check_leds("random_commands", op[3:0], o_leds);       // Opcode was last byte.
  endtask

  task automatic test_unknown_opcode();
    int      i;
    opcode_t bad_ops [4] = '{8'h00, 8'h21, 8'h28, 8'hFF};
    for (i = 0; i < 4; i++) run_command("unknown_opcode", 8'h77, 8'h11, bad_ops[i]);
  endtask

  task automatic test_back_to_back();
    int      s, r;
    data_t   got;
    data_t   a_q [3] = '{8'h81, 8'h3C, 8'hE7};
    data_t   b_q [3] = '{8'h7F, 8'h0D, 8'h04};
    opcode_t op_q [3] = '{OP_ADD, OP_XOR, OP_SRA};
    fork
      for (s = 0; s < 3; s++) begin                      // Nine frames, no gaps.
        send_byte(a_q[s], 1'b0);
        send_byte(b_q[s], 1'b0);
        send_byte(op_q[s], 1'b0);
      end
      for (r = 0; r < 3; r++) begin                      // Results in order.
        recv_byte(got);
        check_data($sformatf("back_to_back_%0d", r),
                   expected_result(op_q[r], a_q[r], b_q[r]), got);
      end
    join
  endtask

  task automatic test_framing_error();
    send_byte(8'h5A, 1'b1);
    repeat (2 * BIT_CLKS) @(negedge i_clock);            // Receiver back to idle.
    check_leds("framing_error", OP_SRA[3:0], o_leds);     // Bad byte never landed.
    run_command("framing_error", 8'h6B, 8'h2C, OP_SUB);
    check_leds("framing_error", OP_SUB[3:0], o_leds);
  endtask

  // Watchdog.
  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the tests finished.");
  end

  initial begin
    i_arst_n = 1'b0;
    i_rxd    = 1'b1;                                     // Line idle.
    repeat (8) @(negedge i_clock);
    i_arst_n = 1'b1;
    test_reset_idle();
    test_each_opcode();
    test_random_commands();
    test_unknown_opcode();
    test_back_to_back();
    test_framing_error();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* filelist.f */
hdl/uart_alu_pkg.sv
hdl/baud_rate_generator.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/alu.sv
hdl/interface_circuit.sv
hdl/uart_alu_top.sv
test/tb_uart_alu_top.sv

/* Bender.yml */
package:
  name: uart_alu

sources:
  # RTL in compile order.
  - files:
      - hdl/uart_alu_pkg.sv
      - hdl/baud_rate_generator.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - hdl/alu.sv
      - hdl/interface_circuit.sv
      - hdl/uart_alu_top.sv
  # Testbench.
  - target: test
    files:
      - test/tb_uart_alu_top.sv
